/* fpAdd_defs.svh */
// Float adder widths and register map
`ifndef FP_ADD_DEFS_SVH
`define FP_ADD_DEFS_SVH

`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_MANT_W   24
`define FP_EXP_MAX  255
`define FP_QNAN     32'h7FC00000

`define APB_ADDR_W  5
`define REG_OPA     5'h00
`define REG_OPB     5'h04
`define REG_CTRL    5'h08
`define REG_STATUS  5'h0C
`define REG_RESULT  5'h10

`define CTRL_START  0
`define CTRL_SUB    1
`define STAT_BUSY   0
`define STAT_DONE   1

`endif

/* fpAddPkg.sv */
// Float word type
`default_nettype none

`include "fpAdd_defs.svh"

package fpAddPkg;

    // One binary32 word, seen as a bus word or as its fields
    typedef union packed
    {
        logic [`FP_EXP_W+`FP_FRAC_W:0] raw;
        struct packed
        {
            logic                  sign;
            logic [`FP_EXP_W-1:0]  exponent;
            logic [`FP_FRAC_W-1:0] fraction;
        } fields;
    } fpWordT;

endpackage

`default_nettype wire

/* fpClassify.sv */
// Float operand classifier
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defs.svh"

module fpClassify
    import fpAddPkg::*;
(
    input  fpWordT opA,
    input  fpWordT opB,
    output logic   aNan,
    output logic   bNan,
    output logic   aInf,
    output logic   bInf,
    output logic   aZero,
    output logic   bZero,
    output logic   aSub,
    output logic   bSub
);

    logic aExpMax, bExpMax, aExpZero, bExpZero;
    logic aFracNz, bFracNz;

    assign aExpMax  = opA.fields.exponent == `FP_EXP_W'(`FP_EXP_MAX);
    assign bExpMax  = opB.fields.exponent == `FP_EXP_W'(`FP_EXP_MAX);
    assign aExpZero = opA.fields.exponent == '0;
    assign bExpZero = opB.fields.exponent == '0;
    assign aFracNz  = |opA.fields.fraction;
    assign bFracNz  = |opB.fields.fraction;

    // All-ones exponent is NaN or infinity, all-zeros is subnormal or zero
    assign aNan  = aExpMax & aFracNz;
    assign bNan  = bExpMax & bFracNz;
    assign aInf  = aExpMax & ~aFracNz;
    assign bInf  = bExpMax & ~bFracNz;
    assign aSub  = aExpZero & aFracNz;
    assign bSub  = bExpZero & bFracNz;
    assign aZero = aExpZero & ~aFracNz;
    assign bZero = bExpZero & ~bFracNz;

endmodule

`default_nettype wire

/* fpAlign.sv */
// Exponent compare and mantissa alignment
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defs.svh"

module fpAlign
    import fpAddPkg::*;
(
    input  fpWordT                opA,
    input  fpWordT                opB,
    input  logic                  aNan,
    input  logic                  bNan,
    input  logic                  aInf,
    input  logic                  bInf,
    input  logic                  aZero,
    input  logic                  bZero,
    input  logic                  aSub,
    input  logic                  bSub,
    output logic [`FP_EXP_W-1:0]  exponentOut,
    output logic [`FP_MANT_W-1:0] alignedMantissaA,
    output logic [`FP_MANT_W-1:0] alignedMantissaB,
    output logic                  guardBit,
    output logic                  roundBit,
    output logic                  stickyBit,
    output logic                  bypass
);

    localparam int ShiftLimit = `FP_MANT_W + 2;

    logic [`FP_EXP_W-1:0]  expA, expB, expDiff;
    logic [`FP_MANT_W-1:0] mantA, mantB, shiftedMant;
    logic [`FP_MANT_W+1:0] extSmall, lostMask;
    logic [4:0]            shiftAmt;
    logic                  aLarger;

    // Subnormals behave as exponent 1 with no hidden bit
    assign expA  = aSub ? `FP_EXP_W'(1) : opA.fields.exponent;
    assign expB  = bSub ? `FP_EXP_W'(1) : opB.fields.exponent;
    assign mantA = {~aSub, opA.fields.fraction};
    assign mantB = {~bSub, opB.fields.fraction};

    assign aLarger  = expA >= expB;
    assign expDiff  = aLarger ? expA - expB : expB - expA;
    assign shiftAmt = (expDiff > `FP_EXP_W'(ShiftLimit)) ? 5'(ShiftLimit) : expDiff[4:0];

    // Two spare low bits catch guard and round
    assign extSmall = aLarger ? {mantB, 2'b00} : {mantA, 2'b00};
    assign lostMask = ~({(`FP_MANT_W+2){1'b1}} << shiftAmt);

    assign bypass = aNan | bNan | aInf | bInf | aZero | bZero;

    always_comb
    begin
        exponentOut      = '0;
        alignedMantissaA = '0;
        alignedMantissaB = '0;
        shiftedMant      = '0;
        {guardBit, roundBit, stickyBit} = '0;

        if (!bypass)
        begin
            exponentOut = aLarger ? expA : expB;
            {shiftedMant, guardBit, roundBit} = extSmall >> shiftAmt;
            // Everything pushed past the round bit folds into sticky
            stickyBit = |(extSmall & lostMask);

            if (aLarger)
            begin
                alignedMantissaA = mantA;
                alignedMantissaB = shiftedMant;
            end
            else
            begin
                alignedMantissaA = shiftedMant;
                alignedMantissaB = mantB;
            end
        end
    end

endmodule

`default_nettype wire

/* fpAddNormRound.sv */
// Mantissa add, normalize and round
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defs.svh"

module fpAddNormRound
    import fpAddPkg::*;
(
    input  logic                  signA,
    input  logic                  signB,
    input  logic                  subtract,
    input  logic [`FP_EXP_W-1:0]  exponentIn,
    input  logic [`FP_MANT_W-1:0] alignedMantissaA,
    input  logic [`FP_MANT_W-1:0] alignedMantissaB,
    input  logic                  guardBit,
    input  logic                  roundBit,
    input  logic                  stickyBit,
    input  logic                  bypass,
    input  logic                  aNan,
    input  logic                  bNan,
    input  logic                  aInf,
    input  logic                  bInf,
    input  logic                  aZero,
    input  logic                  bZero,
    input  logic                  aSub,
    input  logic                  bSub,
    input  fpWordT                opA,
    input  fpWordT                opB,
    output fpWordT                result
);

    logic                  effSignB, sameSign, aGeB, resSign, roundUp;
    logic [`FP_MANT_W+3:0] extLarge, extSmall, sum;
    logic [`FP_MANT_W+2:0] norm;
    logic [4:0]            lz, leftShift;
    logic [`FP_EXP_W-1:0]  expLimit;
    logic [`FP_EXP_W+1:0]  expNorm, expFinal;
    logic [`FP_MANT_W:0]   rounded;
    logic [`FP_MANT_W-1:0] mantFinal;
    fpWordT                arithResult, specialResult;

    assign effSignB = signB ^ subtract;
    assign sameSign = signA == effSignB;

    // The shifted operand is always the smaller one, so GRS follow it
    assign aGeB     = alignedMantissaA >= alignedMantissaB;
    assign extLarge = {1'b0, (aGeB ? alignedMantissaA : alignedMantissaB), 3'b000};
    assign extSmall = {1'b0, (aGeB ? alignedMantissaB : alignedMantissaA),
                       guardBit, roundBit, stickyBit};
    assign sum      = sameSign ? extLarge + extSmall : extLarge - extSmall;
    assign resSign  = sameSign ? signA : (aGeB ? signA : effSignB);
    assign expLimit = exponentIn - `FP_EXP_W'(1);

    always_comb
    begin
        lz = 5'd27;
        for (int i = 0; i < `FP_MANT_W + 3; i++)
        begin
            if (sum[i])
                lz = 5'(26 - i);
        end
        // Left shift stops at the subnormal limit
        leftShift = ({3'b000, lz} <= expLimit) ? lz : expLimit[4:0];

        if (sum[`FP_MANT_W+3])
        begin
            norm    = {sum[`FP_MANT_W+3:2], |sum[1:0]};
            expNorm = {2'b00, exponentIn} + 10'd1;
        end
        else
        begin
            norm    = sum[`FP_MANT_W+2:0] << leftShift;
            expNorm = {2'b00, exponentIn} - {5'b00000, leftShift};
        end

        // Round to nearest even
        // Two subnormals add exactly
        roundUp = ~(aSub & bSub) & norm[2] & (norm[1] | norm[0] | norm[3]);
        rounded = {1'b0, norm[`FP_MANT_W+2:3]} + {{`FP_MANT_W{1'b0}}, roundUp};
        if (rounded[`FP_MANT_W])
        begin
            mantFinal = rounded[`FP_MANT_W:1];
            expFinal  = expNorm + 10'd1;
        end
        else
        begin
            mantFinal = rounded[`FP_MANT_W-1:0];
            expFinal  = expNorm;
        end

        arithResult.fields.sign     = resSign;
        arithResult.fields.fraction = mantFinal[`FP_FRAC_W-1:0];
        if (sum == '0)
        begin
            arithResult.raw = '0;
        end
        else if (expFinal >= 10'(`FP_EXP_MAX))
        begin
            arithResult.fields.exponent = `FP_EXP_W'(`FP_EXP_MAX);
            arithResult.fields.fraction = '0;
        end
        else
        begin
            // No hidden bit left means a subnormal result
            arithResult.fields.exponent = mantFinal[`FP_MANT_W-1] ? expFinal[`FP_EXP_W-1:0] : '0;
        end
    end

    always_comb
    begin
        specialResult.raw = `FP_QNAN;
        if (aNan || bNan || (aInf && bInf && !sameSign))
            specialResult.raw = `FP_QNAN;
        else if (aInf)
            specialResult = opA;
        else if (bInf || (aZero && !bZero))
        begin
            specialResult             = opB;
            specialResult.fields.sign = effSignB;
        end
        else if (aZero && bZero)
        begin
            specialResult             = '0;
            specialResult.fields.sign = signA & effSignB;
        end
        else
            specialResult = opA;
    end

    assign result = bypass ? specialResult : arithResult;

endmodule

`default_nettype wire

/* fpAddRegs.sv */
// APB register block for the float adder
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defs.svh"

module fpAddRegs
    import fpAddPkg::*;
(
    input  logic                   pclk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    input  logic                   resultValid,
    input  fpWordT                 result,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output fpWordT                 opA,
    output fpWordT                 opB,
    output logic                   subtract,
    output logic                   start
);

    logic        wrEn, rdSetup, ctrlWrite, busy, done;
    logic [31:0] readData;
    fpWordT      resultReg;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wrEn    = psel & penable & pwrite;
    assign rdSetup = psel & ~penable & ~pwrite;
    // CTRL writes are dropped while an operation is in flight
    assign ctrlWrite = wrEn && (paddr == `REG_CTRL) && !busy && !start;

    always_comb
    begin
        readData = '0;
        case (paddr)
            `REG_OPA:    readData = opA.raw;
            `REG_OPB:    readData = opB.raw;
            `REG_CTRL:   readData[`CTRL_SUB] = subtract;
            `REG_STATUS:
            begin
                readData[`STAT_BUSY] = busy;
                readData[`STAT_DONE] = done;
            end
            `REG_RESULT: readData = resultReg.raw;
            default:     readData = '0;
        endcase
    end

    always_ff @(posedge pclk or negedge rstN)
    begin
        if (!rstN)
        begin
            opA       <= '0;
            opB       <= '0;
            subtract  <= 1'b0;
            start     <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            resultReg <= '0;
            prdata    <= '0;
        end
        else
        begin
            if (wrEn && paddr == `REG_OPA)
                opA.raw <= pwdata;
            if (wrEn && paddr == `REG_OPB)
                opB.raw <= pwdata;
            if (ctrlWrite)
                subtract <= pwdata[`CTRL_SUB];
            start <= ctrlWrite & pwdata[`CTRL_START];

            if (start)
            begin
                busy <= 1'b1;
                done <= 1'b0;
            end
            else if (resultValid)
            begin
                busy      <= 1'b0;
                done      <= 1'b1;
            end
            if (resultValid)
                resultReg <= result;

            // Read data is ready for the access phase
            if (rdSetup)
                prdata <= readData;
        end
    end

endmodule

`default_nettype wire

/* fpAddTop.sv */
// Float adder with APB slave port
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defs.svh"

module fpAddTop
    import fpAddPkg::*;
(
    input  logic                   pclk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);

    fpWordT                opA, opB, nrResult, s1OpA, s1OpB, s2Result;
    logic                  subtract, start, resultValid;
    logic                  aNan, bNan, aInf, bInf, aZero, bZero, aSub, bSub;
    logic [`FP_EXP_W-1:0]  exponent;
    logic [`FP_MANT_W-1:0] mantA, mantB;
    logic                  guardBit, roundBit, stickyBit, bypass;

    // Stage 1 state
    logic                  s1Valid, s1Subtract, s1Guard, s1Round, s1Sticky, s1Bypass;
    logic                  s1ANan, s1BNan, s1AInf, s1BInf, s1AZero, s1BZero, s1ASub, s1BSub;
    logic [`FP_EXP_W-1:0]  s1Exponent;
    logic [`FP_MANT_W-1:0] s1MantA, s1MantB;

    fpAddRegs regs (
        .pclk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .resultValid, .result(s2Result),
        .prdata, .pready, .pslverr, .opA, .opB, .subtract, .start
    );

    fpClassify classify (
        .opA, .opB, .aNan, .bNan, .aInf, .bInf, .aZero, .bZero, .aSub, .bSub
    );

    fpAlign align (
        .opA, .opB, .aNan, .bNan, .aInf, .bInf, .aZero, .bZero, .aSub, .bSub,
        .exponentOut(exponent), .alignedMantissaA(mantA), .alignedMantissaB(mantB),
        .guardBit, .roundBit, .stickyBit, .bypass
    );

    fpAddNormRound normRound (
        .signA(s1OpA.fields.sign), .signB(s1OpB.fields.sign), .subtract(s1Subtract),
        .exponentIn(s1Exponent), .alignedMantissaA(s1MantA), .alignedMantissaB(s1MantB),
        .guardBit(s1Guard), .roundBit(s1Round), .stickyBit(s1Sticky), .bypass(s1Bypass),
        .aNan(s1ANan), .bNan(s1BNan), .aInf(s1AInf), .bInf(s1BInf),
        .aZero(s1AZero), .bZero(s1BZero), .aSub(s1ASub), .bSub(s1BSub),
        .opA(s1OpA), .opB(s1OpB), .result(nrResult)
    );

    always_ff @(posedge pclk or negedge rstN)
    begin
        if (!rstN)
        begin
            s1Valid     <= 1'b0;
            resultValid <= 1'b0;
        end
        else
        begin
            s1Valid     <= start;
            resultValid <= s1Valid;
        end
    end

    // Payload moves only with its valid bit
    always_ff @(posedge pclk)
    begin
        if (start)
        begin
            s1OpA      <= opA;
            s1OpB      <= opB;
            s1Subtract <= subtract;
            s1Exponent <= exponent;
            s1MantA    <= mantA;
            s1MantB    <= mantB;
            {s1Guard, s1Round, s1Sticky, s1Bypass} <= {guardBit, roundBit, stickyBit, bypass};
            {s1ANan, s1BNan, s1AInf, s1BInf} <= {aNan, bNan, aInf, bInf};
            {s1AZero, s1BZero, s1ASub, s1BSub} <= {aZero, bZero, aSub, bSub};
        end
        if (s1Valid)
            s2Result <= nrResult;
    end

endmodule

`default_nettype wire

/* tbFpAdd.sv */
// Float adder testbench
`timescale 1ns/1ps
`default_nettype none

`include "fpAdd_defs.svh"

module tbFpAdd;

    localparam int ClkHalf        = 4;
    localparam int MaxPolls       = 20;
    localparam int WatchdogCycles = 400 * 40;

    logic        pclk;
    logic        rstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] rngState;
    logic [31:0] randA, randB, randW, readWord;

    fpAddTop uut (
        .pclk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #(ClkHalf) pclk = ~pclk;

    task automatic failRun();
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        assert (got === expected)
        else
        begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, what, expected, got);
            failRun();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    // Exact value of a binary32 word
    function automatic real toReal(input logic [31:0] w);
        logic [31:0] mant;
        int          e;
        real         mag;
        mant = {8'd0, w[30:23] != 8'd0, w[22:0]};
        e    = (w[30:23] == 8'd0) ? 1 : int'(w[30:23]);
        mag  = real'(mant) * (2.0 ** (e - 150));
        return w[31] ? -mag : mag;
    endfunction

    // Double to binary32 with nearest even, gradual underflow and overflow to infinity
    function automatic logic [31:0] fromReal(input real v);
        logic [63:0] d, mant, rem, half, kept;
        int          fe, shift;
        longint      total;
        d     = $realtobits(v);
        mant  = {11'd0, 1'b1, d[51:0]};
        fe    = int'(d[62:52]) - 1023 + 127;
        shift = 29;
        if (fe < 1)
        begin
            shift = 29 + 1 - fe;
            fe    = 1;
        end
        if (shift > 60)
            shift = 60;
        kept = mant >> shift;
        rem  = mant & ((64'd1 << shift) - 64'd1);
        half = 64'd1 << (shift - 1);
        if (rem > half || (rem == half && kept[0]))
            kept = kept + 64'd1;
        // A carry out of the mantissa runs into the exponent field
        total = (longint'(fe - 1) << 23) + longint'(kept);
        if (total >= (longint'(255) << 23))
            return {d[63], 8'hFF, 23'd0};
        return {d[63], total[30:0]};
    endfunction

    function automatic logic [31:0] refAdd(input logic [31:0] a, input logic [31:0] b,
                                           input logic sub);
        logic aNan, bNan, aInf, bInf, effSignB;
        real  v;
        aNan     = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
        bNan     = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
        aInf     = (a[30:23] == 8'hFF) && (a[22:0] == 23'd0);
        bInf     = (b[30:23] == 8'hFF) && (b[22:0] == 23'd0);
        effSignB = b[31] ^ sub;
        if (aNan || bNan || (aInf && bInf && a[31] != effSignB))
            return `FP_QNAN;
        if (aInf)
            return a;
        if (bInf)
            return {effSignB, b[30:0]};
        if (a[30:0] == 31'd0 && b[30:0] == 31'd0)
            return {a[31] & effSignB, 31'd0};
        v = sub ? toReal(a) - toReal(b) : toReal(a) + toReal(b);
        if (v == 0.0)
            return 32'h0;
        return fromReal(v);
    endfunction

    // One APB transfer followed by an idle cycle
    task automatic apbAccess(input logic write, input logic [4:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge pclk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge pclk);
        #1;
        penable = 1'b1;
        #2;
        rdata = prdata;
        checkValue({31'd0, pready}, 32'd1, "pready");
        checkValue({31'd0, pslverr}, 32'd0, "pslverr");
        @(posedge pclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic waitDone();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[`STAT_DONE])
        begin
            if (polls == MaxPolls)
            begin
                $display("DONE was never set after START at %0t ns", $time);
                failRun();
            end
            apbAccess(1'b0, `REG_STATUS, '0, status);
            polls++;
        end
        checkValue(status, 32'h2, "STATUS when done");
    endtask

    task automatic runOp(input logic [31:0] a, input logic [31:0] b, input logic sub);
        logic [31:0] got;
        apbAccess(1'b1, `REG_OPA, a, got);
        apbAccess(1'b1, `REG_OPB, b, got);
        apbAccess(1'b1, `REG_CTRL, {30'd0, sub, 1'b1}, got);
        waitDone();
        apbAccess(1'b0, `REG_RESULT, '0, got);
        checkValue(got, refAdd(a, b, sub), $sformatf("%h %s %h", a, sub ? "-" : "+", b));
    endtask

    // Exponents lean toward the range ends and toward the other operand
    task automatic randomOperand(input logic [7:0] nearExp, output logic [31:0] w);
        logic [31:0] r, f;
        logic [7:0]  e;
        nextRandom(r);
        nextRandom(f);
        case (r[2:0])
            3'd0:       e = 8'd0;
            3'd1:       e = 8'd1;
            3'd2:       e = 8'd254;
            3'd3:       e = 8'd255;
            3'd4, 3'd5: e = nearExp + {5'd0, r[5:3]} - 8'd3;
            default:    e = r[15:8];
        endcase
        w = {r[31], e, (r[7:6] == 2'b00) ? 23'd0 : f[22:0]};
    endtask

    initial
    begin
        repeat (WatchdogCycles) @(posedge pclk);
        $display("Timeout: the run took longer than the watchdog allows");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        pclk     = 1'b0;
        rstN     = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        rngState = 32'd35174;
        repeat (5) @(posedge pclk);
        #1;
        rstN = 1'b1;

        // Register readback and unmapped offsets
        apbAccess(1'b1, `REG_OPA, 32'h3F800000, readWord);
        apbAccess(1'b1, `REG_OPB, 32'h40000000, readWord);
        apbAccess(1'b0, `REG_OPA, '0, readWord);
        checkValue(readWord, 32'h3F800000, "OPA readback");
        apbAccess(1'b0, `REG_OPB, '0, readWord);
        checkValue(readWord, 32'h40000000, "OPB readback");
        apbAccess(1'b0, 5'h14, '0, readWord);
        checkValue(readWord, 32'h0, "unmapped 0x14");
        apbAccess(1'b0, 5'h1C, '0, readWord);
        checkValue(readWord, 32'h0, "unmapped 0x1C");

        // BUSY then DONE
        apbAccess(1'b1, `REG_CTRL, 32'h1, readWord);
        apbAccess(1'b0, `REG_STATUS, '0, readWord);
        checkValue(readWord, 32'h1, "STATUS after START");
        waitDone();
        apbAccess(1'b0, `REG_RESULT, '0, readWord);
        checkValue(readWord, refAdd(32'h3F800000, 32'h40000000, 1'b0), "first result");

        // Second START lands while the first is still busy
        apbAccess(1'b1, `REG_OPA, 32'h40A00000, readWord);
        apbAccess(1'b1, `REG_CTRL, 32'h1, readWord);
        apbAccess(1'b1, `REG_CTRL, 32'h3, readWord);
        waitDone();
        apbAccess(1'b0, `REG_RESULT, '0, readWord);
        checkValue(readWord, refAdd(32'h40A00000, 32'h40000000, 1'b0), "START while busy");
        apbAccess(1'b0, `REG_CTRL, '0, readWord);
        checkValue(readWord, 32'h0, "CTRL after ignored START");

        // Normal operands, sticky and ties
        runOp(32'h3F800000, 32'h3F800000, 1'b0);
        runOp(32'h3FC00000, 32'h3FA00000, 1'b1);
        runOp(32'h40490FDB, 32'h40490FDB, 1'b1);
        runOp(32'hC1200000, 32'h40A00000, 1'b0);
        runOp(32'h3F800000, 32'h33800000, 1'b0);
        runOp(32'h3F800001, 32'h33800000, 1'b0);
        runOp(32'h3F800000, 32'h33800001, 1'b0);
        runOp(32'h3F800000, 32'h33800001, 1'b1);
        runOp(32'h4B000000, 32'h3F000000, 1'b0);
        runOp(32'h7F000000, 32'h3F800000, 1'b1);

        // Special operands
        runOp(32'h7FC00000, 32'h3F800000, 1'b0);
        runOp(32'h7F800001, 32'h00000000, 1'b1);
        runOp(32'h7F800000, 32'h7F800000, 1'b1);
        runOp(32'h7F800000, 32'hFF800000, 1'b0);
        runOp(32'hFF800000, 32'h3F800000, 1'b0);
        runOp(32'h3F800000, 32'h7F800000, 1'b1);
        runOp(32'h00000000, 32'h40400000, 1'b1);
        runOp(32'hC0400000, 32'h80000000, 1'b0);
        runOp(32'h80000000, 32'h80000000, 1'b0);
        runOp(32'h80000000, 32'h00000000, 1'b1);
        runOp(32'h00000000, 32'h00000000, 1'b1);
        runOp(32'h80000000, 32'h00000000, 1'b0);

        // Subnormals
        runOp(32'h00000001, 32'h00000001, 1'b0);
        runOp(32'h00400000, 32'h00400000, 1'b0);
        runOp(32'h00000003, 32'h3F800000, 1'b0);
        runOp(32'h00800000, 32'h00000001, 1'b1);
        runOp(32'h00800001, 32'h00800000, 1'b1);
        runOp(32'h80400000, 32'h00200000, 1'b0);

        // Overflow
        runOp(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0);
        runOp(32'hFF7FFFFF, 32'hFF7FFFFF, 1'b0);
        runOp(32'h7F7FFFFF, 32'hFF7FFFFF, 1'b1);
        runOp(32'h7F7FFFFF, 32'h73000000, 1'b0);

        for (int i = 0; i < 300; i++)
        begin
            nextRandom(randW);
            randomOperand(randW[15:8], randA);
            randomOperand(randA[30:23], randB);
            runOp(randA, randB, randW[0]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
fpAddPkg.sv
fpClassify.sv
fpAlign.sv
fpAddNormRound.sv
fpAddRegs.sv
fpAddTop.sv
tbFpAdd.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tbFpAdd
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
